// File: design/ooo_pkg.sv
// Shared value types, instruction kind enum and dispatch FSM states
`default_nettype none

package ooo_pkg;

    // PC and branch target values
    typedef logic [31:0] xlen_t;

    // Architectural register number
    typedef logic [4:0] arn_t;

    // Physical register number
    typedef logic [5:0] prn_t;

    // Execution latency in cycles, zero behaves as one
    typedef logic [2:0] lat_t;

    // Only ALU instructions write a register
    typedef enum logic [0:0] {
        KIND_ALU    = 1'b0,
        KIND_BRANCH = 1'b1
    } instr_kind_e;

    // Four-phase receiver states
    typedef enum logic [1:0] {
        DISP_IDLE     = 2'd0,
        DISP_ACK      = 2'd1,
        DISP_WAIT_LOW = 2'd2
    } disp_state_e;

endpackage

`default_nettype wire

// File: design/core_ifs.sv
// Allocation bus and completion bus interfaces with their modports
`timescale 1ns/1ps
`default_nettype none

interface alloc_if #(
    parameter int ROB_DEPTH = 16
) ();
    import ooo_pkg::*;

    localparam int IDX_W = $clog2(ROB_DEPTH);

    logic              valid;
    logic              stall;
    logic [IDX_W-1:0]  rob_idx;
    instr_kind_e       kind;
    arn_t              arn;
    prn_t              prn;
    logic              reg_write;
    xlen_t             pc;
    logic              pred_taken;
    xlen_t             pred_target;
    logic              act_taken;
    xlen_t             act_target;
    lat_t              latency;

    modport disp (
        output valid, kind, arn, prn, reg_write, pc, pred_taken, pred_target,
        output act_taken, act_target, latency,
        input  stall
    );

    // The ROB supplies the slot index, which is its tail
    modport rob (
        input  valid, stall, kind, arn, prn, reg_write, pc, pred_taken, pred_target,
        output rob_idx
    );

    modport exec (
        input  valid, stall, rob_idx, act_taken, act_target, latency
    );
endinterface

interface cdb_if #(
    parameter int ROB_DEPTH = 16
) ();
    import ooo_pkg::*;

    localparam int IDX_W = $clog2(ROB_DEPTH);

    logic              valid;
    logic [IDX_W-1:0]  rob_idx;
    logic              act_taken;
    xlen_t             act_target;

    modport exec (output valid, rob_idx, act_taken, act_target);
    modport rob  (input  valid, rob_idx, act_taken, act_target);
endinterface

`default_nettype wire

// File: design/dispatch_stage.sv
// Dispatch stage: four-phase instruction receiver that allocates ROB slots
`timescale 1ns/1ps
`default_nettype none

module dispatch_stage (
    input  logic                 clock,
    input  logic                 rst_n,
    input  logic                 flush,
    input  logic                 in_req,
    output logic                 in_ack,
    input  ooo_pkg::instr_kind_e in_kind,
    input  ooo_pkg::arn_t        in_arn,
    input  ooo_pkg::prn_t        in_prn,
    input  ooo_pkg::xlen_t       in_pc,
    input  logic                 in_pred_taken,
    input  ooo_pkg::xlen_t       in_pred_target,
    input  logic                 in_act_taken,
    input  ooo_pkg::xlen_t       in_act_target,
    input  ooo_pkg::lat_t        in_latency,
    alloc_if.disp                alloc
);
    import ooo_pkg::*;

    disp_state_e state;

    // Source keeps the fields stable while in_req is high
    assign alloc.kind        = in_kind;
    assign alloc.arn         = in_arn;
    assign alloc.prn         = in_prn;
    assign alloc.reg_write   = (in_kind == KIND_ALU);
    assign alloc.pc          = in_pc;
    assign alloc.pred_taken  = in_pred_taken;
    assign alloc.pred_target = in_pred_target;
    assign alloc.act_taken   = in_act_taken;
    assign alloc.act_target  = in_act_target;
    assign alloc.latency     = in_latency;

    // No allocation while the backend is being flushed
    assign alloc.valid = (state == DISP_ACK) && !flush;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state  <= DISP_IDLE;
            in_ack <= 1'b0;
        end else begin
            case (state)
                DISP_IDLE: begin
                    if (in_req) begin
                        state <= DISP_ACK;
                    end
                end
                DISP_ACK: begin
                    // Ack rises on the edge that takes the allocation
                    if (alloc.valid && !alloc.stall) begin
                        state  <= DISP_WAIT_LOW;
                        in_ack <= 1'b1;
                    end
                end
                DISP_WAIT_LOW: begin
                    if (!in_req) begin
                        state  <= DISP_IDLE;
                        in_ack <= 1'b0;
                    end
                end
                default: state <= DISP_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: design/exec_stage.sv
// Execute stage: latency countdown slots with oldest-first completion bus
`timescale 1ns/1ps
`default_nettype none

module exec_stage #(
    parameter int ROB_DEPTH  = 16,
    parameter int EXEC_SLOTS = 4
) (
    input  logic  clock,
    input  logic  rst_n,
    input  logic  flush,
    alloc_if.exec alloc,
    output logic  slots_full,
    cdb_if.exec   cdb
);
    import ooo_pkg::*;

    localparam int IDX_W  = $clog2(ROB_DEPTH);
    localparam int SLOT_W = (EXEC_SLOTS > 1) ? $clog2(EXEC_SLOTS) : 1;
    localparam int AGE_W  = $clog2(EXEC_SLOTS + 1);

    logic [EXEC_SLOTS-1:0] slot_valid;
    logic [IDX_W-1:0]      slot_idx    [EXEC_SLOTS];
    logic                  slot_taken  [EXEC_SLOTS];
    xlen_t                 slot_target [EXEC_SLOTS];
    lat_t                  slot_rem    [EXEC_SLOTS];
    // Age 0 is the oldest slot, ages stay dense
    logic [AGE_W-1:0]      slot_age    [EXEC_SLOTS];

    logic [AGE_W-1:0]      occupancy;
    logic                  sel_found;
    logic [SLOT_W-1:0]     sel_slot;
    logic [AGE_W-1:0]      sel_age;
    logic                  free_found;
    logic [SLOT_W-1:0]     free_slot;
    logic                  take;

    always_comb begin
        occupancy  = '0;
        sel_found  = 1'b0;
        sel_slot   = '0;
        sel_age    = '0;
        free_found = 1'b0;
        free_slot  = '0;
        for (int i = 0; i < EXEC_SLOTS; i++) begin
            if (slot_valid[i]) begin
                occupancy = occupancy + 1'b1;
                // Ready slot with the smallest age wins the bus
                if (slot_rem[i] == '0 && (!sel_found || slot_age[i] < sel_age)) begin
                    sel_found = 1'b1;
                    sel_slot  = SLOT_W'(i);
                    sel_age   = slot_age[i];
                end
            end else if (!free_found) begin
                free_found = 1'b1;
                free_slot  = SLOT_W'(i);
            end
        end
    end

    assign slots_full = (occupancy == AGE_W'(EXEC_SLOTS));
    assign take       = alloc.valid && !alloc.stall && free_found;

    assign cdb.valid      = sel_found && !flush;
    assign cdb.rob_idx    = slot_idx[sel_slot];
    assign cdb.act_taken  = slot_taken[sel_slot];
    assign cdb.act_target = slot_target[sel_slot];

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            slot_valid <= '0;
        end else if (flush) begin
            slot_valid <= '0;
        end else begin
            if (sel_found) slot_valid[sel_slot] <= 1'b0;
            if (take) slot_valid[free_slot] <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        for (int i = 0; i < EXEC_SLOTS; i++) begin
            if (slot_valid[i]) begin
                if (slot_rem[i] != '0) slot_rem[i] <= slot_rem[i] - 1'b1;
                // Close the gap left by the completing slot
                if (sel_found && slot_age[i] > sel_age) slot_age[i] <= slot_age[i] - 1'b1;
            end
        end
        if (take) begin
            slot_idx[free_slot]    <= alloc.rob_idx;
            slot_taken[free_slot]  <= alloc.act_taken;
            slot_target[free_slot] <= alloc.act_target;
            slot_rem[free_slot]    <= (alloc.latency == '0) ? lat_t'(1) : alloc.latency;
            slot_age[free_slot]    <= sel_found ? occupancy - 1'b1 : occupancy;
        end
    end

endmodule

`default_nettype wire

// File: design/rob.sv
// Reorder buffer with completion tracking, in-order multi-way commit and flush
`timescale 1ns/1ps
`default_nettype none

module rob #(
    parameter int ROB_DEPTH   = 16,
    parameter int COMMIT_WAYS = 2
) (
    input  logic                               clock,
    input  logic                               rst_n,
    alloc_if.rob                               alloc,
    output logic                               full,
    cdb_if.rob                                 cdb,
    output logic                               flush,
    output ooo_pkg::xlen_t                     redirect_pc,
    output logic [COMMIT_WAYS-1:0]             commit_valid,
    output ooo_pkg::xlen_t [COMMIT_WAYS-1:0]   commit_pc,
    output ooo_pkg::arn_t  [COMMIT_WAYS-1:0]   commit_arn,
    output ooo_pkg::prn_t  [COMMIT_WAYS-1:0]   commit_prn,
    output logic [COMMIT_WAYS-1:0]             commit_reg_write,
    output logic [$clog2(ROB_DEPTH):0]         free_count
);
    import ooo_pkg::*;

    localparam int IDX_W = $clog2(ROB_DEPTH);
    localparam int CNT_W = IDX_W + 1;
    localparam int WAY_W = $clog2(COMMIT_WAYS + 1);

    // Entry storage
    instr_kind_e          ent_kind        [ROB_DEPTH];
    arn_t                 ent_arn         [ROB_DEPTH];
    prn_t                 ent_prn         [ROB_DEPTH];
    logic                 ent_reg_write   [ROB_DEPTH];
    xlen_t                ent_pc          [ROB_DEPTH];
    logic                 ent_pred_taken  [ROB_DEPTH];
    xlen_t                ent_pred_target [ROB_DEPTH];
    logic                 ent_act_taken   [ROB_DEPTH];
    xlen_t                ent_act_target  [ROB_DEPTH];
    logic [ROB_DEPTH-1:0] ent_done;
    logic [ROB_DEPTH-1:0] ent_mispred;

    logic [IDX_W-1:0]       head;
    logic [IDX_W-1:0]       tail;
    logic [CNT_W-1:0]       count;
    logic                   take;
    logic                   cdb_mispred;
    logic                   stop;
    logic [WAY_W-1:0]       num_commit;
    logic [COMMIT_WAYS-1:0] lane_commit;
    logic [IDX_W-1:0]       lane_idx [COMMIT_WAYS];
    logic                   do_flush;
    xlen_t                  flush_target;

    assign take          = alloc.valid && !alloc.stall;
    assign alloc.rob_idx = tail;
    assign full          = (count == CNT_W'(ROB_DEPTH));
    assign free_count    = CNT_W'(ROB_DEPTH) - count;

    // Wrong direction, or right direction with a different taken target
    assign cdb_mispred = (cdb.act_taken != ent_pred_taken[cdb.rob_idx]) ||
                         (cdb.act_taken && cdb.act_target != ent_pred_target[cdb.rob_idx]);

    always_comb begin
        num_commit   = '0;
        lane_commit  = '0;
        do_flush     = 1'b0;
        flush_target = '0;
        // Nothing retires in the flush cycle
        stop         = flush;
        for (int w = 0; w < COMMIT_WAYS; w++) begin
            lane_idx[w] = head + IDX_W'(w);
            if (!stop && CNT_W'(w) < count && ent_done[lane_idx[w]]) begin
                lane_commit[w] = 1'b1;
                num_commit     = num_commit + 1'b1;
                if (ent_kind[lane_idx[w]] == KIND_BRANCH && ent_mispred[lane_idx[w]]) begin
                    do_flush     = 1'b1;
                    flush_target = ent_act_taken[lane_idx[w]] ? ent_act_target[lane_idx[w]]
                                                              : ent_pc[lane_idx[w]] + 32'd4;
                    stop         = 1'b1;
                end
            end else begin
                stop = 1'b1;
            end
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            head         <= '0;
            tail         <= '0;
            count        <= '0;
            ent_done     <= '0;
            ent_mispred  <= '0;
            commit_valid <= '0;
            flush        <= 1'b0;
        end else begin
            commit_valid <= lane_commit;
            flush        <= do_flush;
            if (flush) begin
                // Drop everything younger than the branch
                head  <= tail;
                count <= '0;
            end else begin
                head  <= head + IDX_W'(num_commit);
                tail  <= tail + IDX_W'(take);
                count <= count + CNT_W'(take) - CNT_W'(num_commit);
            end
            if (cdb.valid) begin
                ent_done[cdb.rob_idx]    <= 1'b1;
                ent_mispred[cdb.rob_idx] <= cdb_mispred;
            end
            if (take) begin
                ent_done[tail]    <= 1'b0;
                ent_mispred[tail] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (take) begin
            ent_kind[tail]        <= alloc.kind;
            ent_arn[tail]         <= alloc.arn;
            ent_prn[tail]         <= alloc.prn;
            ent_reg_write[tail]   <= alloc.reg_write;
            ent_pc[tail]          <= alloc.pc;
            ent_pred_taken[tail]  <= alloc.pred_taken;
            ent_pred_target[tail] <= alloc.pred_target;
        end
        if (cdb.valid) begin
            ent_act_taken[cdb.rob_idx]  <= cdb.act_taken;
            ent_act_target[cdb.rob_idx] <= cdb.act_target;
        end
        for (int w = 0; w < COMMIT_WAYS; w++) begin
            commit_pc[w]        <= ent_pc[lane_idx[w]];
            commit_arn[w]       <= ent_arn[lane_idx[w]];
            commit_prn[w]       <= ent_prn[lane_idx[w]];
            commit_reg_write[w] <= ent_reg_write[lane_idx[w]];
        end
        redirect_pc <= flush_target;
    end

endmodule

`default_nettype wire

// File: design/ooo_core_top.sv
// Backend top level: dispatch, execute and reorder buffer with plain ports
`timescale 1ns/1ps
`default_nettype none

module ooo_core_top #(
    parameter int ROB_DEPTH   = 16,
    parameter int COMMIT_WAYS = 2,
    parameter int EXEC_SLOTS  = 4
) (
    input  logic                               clock,
    input  logic                               rst_n,
    input  logic                               in_req,
    input  ooo_pkg::instr_kind_e               in_kind,
    input  ooo_pkg::arn_t                      in_arn,
    input  ooo_pkg::prn_t                      in_prn,
    input  ooo_pkg::xlen_t                     in_pc,
    input  logic                               in_pred_taken,
    input  ooo_pkg::xlen_t                     in_pred_target,
    input  logic                               in_act_taken,
    input  ooo_pkg::xlen_t                     in_act_target,
    input  ooo_pkg::lat_t                      in_latency,
    output logic                               in_ack,
    output logic [COMMIT_WAYS-1:0]             commit_valid,
    output ooo_pkg::xlen_t [COMMIT_WAYS-1:0]   commit_pc,
    output ooo_pkg::arn_t  [COMMIT_WAYS-1:0]   commit_arn,
    output ooo_pkg::prn_t  [COMMIT_WAYS-1:0]   commit_prn,
    output logic [COMMIT_WAYS-1:0]             commit_reg_write,
    output logic                               flush,
    output ooo_pkg::xlen_t                     redirect_pc,
    output logic [$clog2(ROB_DEPTH):0]         free_count
);

    logic rob_full;
    logic slots_full;

    alloc_if #(.ROB_DEPTH(ROB_DEPTH)) alloc_bus ();
    cdb_if   #(.ROB_DEPTH(ROB_DEPTH)) cdb_bus ();

    // Either a full ROB or busy execute slots hold dispatch back
    assign alloc_bus.stall = rob_full | slots_full;

    dispatch_stage u_dispatch (
        .clock          (clock),
        .rst_n          (rst_n),
        .flush          (flush),
        .in_req         (in_req),
        .in_ack         (in_ack),
        .in_kind        (in_kind),
        .in_arn         (in_arn),
        .in_prn         (in_prn),
        .in_pc          (in_pc),
        .in_pred_taken  (in_pred_taken),
        .in_pred_target (in_pred_target),
        .in_act_taken   (in_act_taken),
        .in_act_target  (in_act_target),
        .in_latency     (in_latency),
        .alloc          (alloc_bus.disp)
    );

    exec_stage #(
        .ROB_DEPTH  (ROB_DEPTH),
        .EXEC_SLOTS (EXEC_SLOTS)
    ) u_exec (
        .clock      (clock),
        .rst_n      (rst_n),
        .flush      (flush),
        .alloc      (alloc_bus.exec),
        .slots_full (slots_full),
        .cdb        (cdb_bus.exec)
    );

    rob #(
        .ROB_DEPTH   (ROB_DEPTH),
        .COMMIT_WAYS (COMMIT_WAYS)
    ) u_rob (
        .clock            (clock),
        .rst_n            (rst_n),
        .alloc            (alloc_bus.rob),
        .full             (rob_full),
        .cdb              (cdb_bus.rob),
        .flush            (flush),
        .redirect_pc      (redirect_pc),
        .commit_valid     (commit_valid),
        .commit_pc        (commit_pc),
        .commit_arn       (commit_arn),
        .commit_prn       (commit_prn),
        .commit_reg_write (commit_reg_write),
        .free_count       (free_count)
    );

endmodule

`default_nettype wire

// File: tb/tb_clock_gen.sv
// Testbench clock source and power-on reset generator
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 3
) (
    output logic clock,
    output logic rst_n
);

    initial begin
        clock = 1'b0;
        forever #(PERIOD_NS / 2) clock = ~clock;
    end

    // Reset is released on the edge that ends the last reset cycle
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clock);
        rst_n <= 1'b1;
    end

endmodule

`default_nettype wire

// File: tb/tb_ooo_core.sv
// Backend testbench with random four-phase source, reference model, checkers and watchdog
`timescale 1ns/1ps
`default_nettype none

module tb_ooo_core;
    import ooo_pkg::*;

    localparam int ROB_DEPTH       = 16;
    localparam int COMMIT_WAYS     = 2;
    localparam int EXEC_SLOTS      = 4;
    localparam int CNT_W           = $clog2(ROB_DEPTH) + 1;
    localparam int NUM_INSTR       = 400;
    localparam int WATCHDOG_CYCLES = NUM_INSTR * 40;

    typedef struct packed {
        instr_kind_e kind;
        arn_t        arn;
        prn_t        prn;
        xlen_t       pc;
        logic        pred_taken;
        xlen_t       pred_target;
        logic        act_taken;
        xlen_t       act_target;
        lat_t        latency;
    } instr_t;

    logic                    clock;
    logic                    rst_n;
    logic                    in_req;
    instr_kind_e             in_kind;
    arn_t                    in_arn;
    prn_t                    in_prn;
    xlen_t                   in_pc;
    logic                    in_pred_taken;
    xlen_t                   in_pred_target;
    logic                    in_act_taken;
    xlen_t                   in_act_target;
    lat_t                    in_latency;
    logic                    in_ack;
    logic [COMMIT_WAYS-1:0]  commit_valid;
    xlen_t [COMMIT_WAYS-1:0] commit_pc;
    arn_t  [COMMIT_WAYS-1:0] commit_arn;
    prn_t  [COMMIT_WAYS-1:0] commit_prn;
    logic [COMMIT_WAYS-1:0]  commit_reg_write;
    logic                    flush;
    xlen_t                   redirect_pc;
    logic [CNT_W-1:0]        free_count;

    // Acknowledged instructions that have not yet committed, oldest first
    instr_t model_q[$];
    int     ack_count;
    logic   prev_ack;
    logic   prev_req;

    tb_clock_gen #(.PERIOD_NS(20), .RESET_CYCLES(3)) u_clock_gen (
        .clock (clock),
        .rst_n (rst_n)
    );

    ooo_core_top #(
        .ROB_DEPTH   (ROB_DEPTH),
        .COMMIT_WAYS (COMMIT_WAYS),
        .EXEC_SLOTS  (EXEC_SLOTS)
    ) DUT (
        .clock            (clock),
        .rst_n            (rst_n),
        .in_req           (in_req),
        .in_kind          (in_kind),
        .in_arn           (in_arn),
        .in_prn           (in_prn),
        .in_pc            (in_pc),
        .in_pred_taken    (in_pred_taken),
        .in_pred_target   (in_pred_target),
        .in_act_taken     (in_act_taken),
        .in_act_target    (in_act_target),
        .in_latency       (in_latency),
        .in_ack           (in_ack),
        .commit_valid     (commit_valid),
        .commit_pc        (commit_pc),
        .commit_arn       (commit_arn),
        .commit_prn       (commit_prn),
        .commit_reg_write (commit_reg_write),
        .flush            (flush),
        .redirect_pc      (redirect_pc),
        .free_count       (free_count)
    );

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    // Only a branch can mispredict; a taken branch also needs the right target
    function automatic bit branch_mispredicted(input instr_t ins);
        if (ins.kind != KIND_BRANCH) return 1'b0;
        if (ins.act_taken != ins.pred_taken) return 1'b1;
        return ins.act_taken && (ins.act_target != ins.pred_target);
    endfunction

    function automatic xlen_t expected_redirect(input instr_t ins);
        return ins.act_taken ? ins.act_target : ins.pc + 32'd4;
    endfunction

    function automatic instr_t make_instr(input xlen_t pc, input bit slow);
        instr_t r;
        r.kind        = ($urandom_range(99) < 30) ? KIND_BRANCH : KIND_ALU;
        r.arn         = arn_t'($urandom_range(31));
        r.prn         = prn_t'($urandom_range(63));
        r.pc          = pc;
        r.latency     = slow ? lat_t'(7) : lat_t'($urandom_range(7));
        r.pred_taken  = 1'($urandom_range(1));
        r.pred_target = xlen_t'($urandom()) & 32'hffff_fffc;
        r.act_taken   = r.pred_taken;
        r.act_target  = r.pred_taken ? r.pred_target : xlen_t'($urandom()) & 32'hffff_fffc;
        if (r.kind == KIND_ALU) begin
            // ALU outcome fields are noise and must never cause a flush
            r.act_taken = 1'($urandom_range(1));
        end else if ($urandom_range(3) == 0) begin
            if (r.pred_taken && $urandom_range(1) == 1) r.act_target = r.pred_target + 32'h40;
            else r.act_taken = !r.pred_taken;
        end
        return r;
    endfunction

    task automatic drive_handshake(input instr_t ins);
        @(posedge clock);
        in_kind        <= ins.kind;
        in_arn         <= ins.arn;
        in_prn         <= ins.prn;
        in_pc          <= ins.pc;
        in_pred_taken  <= ins.pred_taken;
        in_pred_target <= ins.pred_target;
        in_act_taken   <= ins.act_taken;
        in_act_target  <= ins.act_target;
        in_latency     <= ins.latency;
        in_req         <= 1'b1;
        @(negedge clock);
        while (!in_ack) @(negedge clock);
        @(posedge clock);
        in_req <= 1'b0;
        @(negedge clock);
        while (in_ack) @(negedge clock);
    endtask

    // Outputs are sampled on the falling edge half a cycle after they change
    always @(negedge clock) begin : monitor
        instr_t rec;
        instr_t front;
        bit     expect_flush;
        bit     lane_gap;
        xlen_t  exp_redirect;
        if (rst_n) begin
            if (in_ack && !prev_ack) begin
                assert (in_req) else abort_run("in_ack rose while in_req was low");
                rec = '{in_kind, in_arn, in_prn, in_pc, in_pred_taken, in_pred_target,
                        in_act_taken, in_act_target, in_latency};
                model_q.push_back(rec);
                ack_count++;
            end
            if (!in_ack && prev_ack) begin
                assert (!prev_req) else abort_run("in_ack fell before in_req was lowered");
            end
            expect_flush = 1'b0;
            lane_gap     = 1'b0;
            exp_redirect = '0;
            for (int w = 0; w < COMMIT_WAYS; w++) begin
                if (commit_valid[w]) begin
                    assert (!lane_gap) else abort_run("commit lanes are not filled from lane 0");
                    assert (!expect_flush) else abort_run("commit went past a mispredicted branch");
                    assert (model_q.size() > 0) else abort_run("commit with nothing outstanding");
                    front = model_q.pop_front();
                    assert (commit_pc[w] == front.pc) else abort_run($sformatf(
                        "FAIL commit_pc[%0d] got %h expected %h", w, commit_pc[w], front.pc));
                    assert (commit_arn[w] == front.arn) else abort_run($sformatf(
                        "FAIL commit_arn[%0d] got %h expected %h", w, commit_arn[w], front.arn));
                    assert (commit_prn[w] == front.prn) else abort_run($sformatf(
                        "FAIL commit_prn[%0d] got %h expected %h", w, commit_prn[w], front.prn));
                    assert (commit_reg_write[w] == (front.kind == KIND_ALU)) else abort_run(
                        $sformatf("FAIL commit_reg_write[%0d] got %h expected %h", w,
                                  commit_reg_write[w], front.kind == KIND_ALU));
                    if (branch_mispredicted(front)) begin
                        expect_flush = 1'b1;
                        exp_redirect = expected_redirect(front);
                    end
                end else begin
                    lane_gap = 1'b1;
                end
            end
            assert (flush == expect_flush) else abort_run($sformatf(
                "FAIL flush got %h expected %h", flush, expect_flush));
            if (flush) begin
                assert (redirect_pc == exp_redirect) else abort_run($sformatf(
                    "FAIL redirect_pc got %h expected %h", redirect_pc, exp_redirect));
                // Everything younger than the branch is squashed
                model_q.delete();
            end
        end
        prev_ack = in_ack;
        prev_req = in_req;
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clock);
        abort_run("Watchdog timeout: the run did not finish in the expected number of cycles");
    end

    initial begin : stimulus
        instr_t           ins;
        int               burst_left;
        int               gap;
        xlen_t            pc_next;
        logic [CNT_W-1:0] final_free;
        void'($urandom(32'h000a_0cba));
        in_req         = 1'b0;
        in_kind        = KIND_ALU;
        in_arn         = '0;
        in_prn         = '0;
        in_pc          = '0;
        in_pred_taken  = 1'b0;
        in_pred_target = '0;
        in_act_taken   = 1'b0;
        in_act_target  = '0;
        in_latency     = '0;
        ack_count      = 0;
        prev_ack       = 1'b0;
        prev_req       = 1'b0;
        burst_left     = 0;
        pc_next        = 32'h0000_1000;

        wait (rst_n === 1'b1);
        @(negedge clock);
        assert (free_count == CNT_W'(ROB_DEPTH)) else abort_run($sformatf(
            "FAIL free_count after reset got %h expected %h", free_count, ROB_DEPTH));
        assert (in_ack == 1'b0) else abort_run($sformatf(
            "FAIL in_ack after reset got %h expected 0", in_ack));
        assert (commit_valid == '0) else abort_run($sformatf(
            "FAIL commit_valid after reset got %h expected 0", commit_valid));
        assert (flush == 1'b0) else abort_run($sformatf(
            "FAIL flush after reset got %h expected 0", flush));

        for (int n = 0; n < NUM_INSTR; n++) begin
            // Occasional back-to-back bursts of slow instructions
            if (burst_left == 0 && $urandom_range(39) == 0) burst_left = 12;
            ins = make_instr(pc_next, burst_left != 0);
            drive_handshake(ins);
            pc_next = pc_next + 32'd4;
            if (burst_left != 0) begin
                burst_left--;
            end else begin
                gap = int'($urandom_range(4));
                repeat (gap) @(posedge clock);
            end
        end

        // Drain until the ROB reports itself empty, then let a few cycles pass
        while (free_count != CNT_W'(ROB_DEPTH)) @(negedge clock);
        repeat (4) @(negedge clock);
        final_free = free_count;
        @(posedge clock);
        assert (ack_count == NUM_INSTR) else abort_run($sformatf(
            "FAIL ack_count got %h expected %h", ack_count, NUM_INSTR));
        assert (final_free == CNT_W'(ROB_DEPTH)) else abort_run($sformatf(
            "FAIL free_count after drain got %h expected %h", final_free, ROB_DEPTH));
        if (model_q.size() == 0) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            abort_run("Instructions were acknowledged but never committed or flushed");
        end
    end

endmodule

`default_nettype wire

// File: all.f
design/ooo_pkg.sv
design/core_ifs.sv
design/dispatch_stage.sv
design/exec_stage.sv
design/rob.sv
design/ooo_core_top.sv
tb/tb_clock_gen.sv
tb/tb_ooo_core.sv

// File: run.sh
#!/bin/sh
# Build the testbench with Verilator and run it; the exit status is the result
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_ooo_core \
    -Mdir obj_dir \
    -f all.f

./obj_dir/Vtb_ooo_core
